/* verilog/sample_fmt_pkg.sv */
package sample_fmt_pkg;

	// one acquisition sample from the front end
	localparam int SAMPLE_W = 16;

	// one word of the bulk buffer and of the host pipe
	localparam int WORD_W = 32;

	typedef logic [SAMPLE_W-1:0] sample_t;
	typedef logic [WORD_W-1:0]   word_t;

	// two samples as they sit in one word
	// early sample in the low half, late sample in the high half
	typedef struct packed {
		sample_t late;
		sample_t early;
	} sample_pair_t;

	// the packer builds the word through the pair view
	// everything downstream only moves the raw word
	typedef union packed {
		word_t        raw;
		sample_pair_t pair;
	} sample_pair_u;

endpackage

/* verilog/buffer_ctrl_pkg.sv */
package buffer_ctrl_pkg;

	// width of the reported fill, in 16-bit samples
	localparam int COUNT_W = 32;

	// width of a stage fill in words
	// wide enough for any depth the top level asks for
	localparam int LEVEL_W = 16;

	typedef logic [COUNT_W-1:0] sample_count_t;
	typedef logic [LEVEL_W-1:0] level_t;

	// sent back from the output FIFO every cycle
	// pop returns one credit to the transfer engine
	// level is the output FIFO fill, for the capacity monitor
	typedef struct packed {
		logic   pop;
		level_t level;
	} credit_ret_t;

endpackage

/* verilog/sample_packer.sv */
`timescale 1ns/1ps

module sample_packer
	import sample_fmt_pkg::*;
(
	input  logic         ti_clk,
	input  logic         rst,
	input  logic         write_en,
	input  sample_t      sample_in,
	output logic         push,
	output sample_pair_u push_word,
	output logic         half_held
);

	// first sample of a pair waiting for its partner
	sample_t held_sample;

	//////////////////////////////
	// pair state
	//////////////////////////////

	always_ff @(posedge ti_clk) begin
		if (rst) begin
			half_held <= 1'b0;
			push      <= 1'b0;
		end else begin
			// push lasts exactly one cycle per completed pair
			push <= write_en & half_held;
			if (write_en) begin
				half_held <= ~half_held;
			end
		end
	end

	// held sample and joined word
	always_ff @(posedge ti_clk) begin
		if (write_en && !half_held) begin
			held_sample <= sample_in;
		end
		if (write_en && half_held) begin
			// low half goes out first on the host side
			push_word.pair.early <= held_sample;
			push_word.pair.late  <= sample_in;
		end
	end

endmodule

/* verilog/mini_fifo.sv */
`timescale 1ns/1ps

module mini_fifo
	import sample_fmt_pkg::*;
	import buffer_ctrl_pkg::*;
#(
	parameter int DEPTH_LOG2 = 4
) (
	input  logic        ti_clk,
	input  logic        rst,
	input  logic        push,
	input  word_t       push_data,
	input  logic        pop,
	output word_t       head,
	output logic        empty,
	output logic        full,
	output level_t      level,
	output credit_ret_t credit_ret
);

	localparam int DEPTH = 1 << DEPTH_LOG2;

	word_t                 mem [DEPTH];
	logic [DEPTH_LOG2-1:0] wr_ptr;
	logic [DEPTH_LOG2-1:0] rd_ptr;
	logic [DEPTH_LOG2:0]   count;
	// last word handed out, shown again when the FIFO runs dry
	word_t                 last_word;
	logic                  do_push;
	logic                  do_pop;

	assign empty = (count == '0);
	assign full  = (count == (DEPTH_LOG2+1)'(DEPTH));

	// writes on full and reads on empty are simply dropped
	assign do_push = push & ~full;
	assign do_pop  = pop & ~empty;

	//////////////////////////////
	// pointers and occupancy
	//////////////////////////////

	always_ff @(posedge ti_clk) begin
		if (rst) begin
			wr_ptr    <= '0;
			rd_ptr    <= '0;
			count     <= '0;
			last_word <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr    <= rd_ptr + 1'b1;
				last_word <= mem[rd_ptr];
			end
			count <= count + (DEPTH_LOG2+1)'(do_push) - (DEPTH_LOG2+1)'(do_pop);
		end
	end

	always_ff @(posedge ti_clk) begin
		if (do_push) begin
			mem[wr_ptr] <= push_data;
		end
	end

	// first-word-fall-through head
	assign head = empty ? last_word : mem[rd_ptr];

	assign level            = level_t'(count);
	assign credit_ret.pop   = do_pop;
	assign credit_ret.level = level;

endmodule

/* verilog/ring_transfer_engine.sv */
`timescale 1ns/1ps

module ring_transfer_engine
	import sample_fmt_pkg::*;
	import buffer_ctrl_pkg::*;
#(
	parameter int RING_DEPTH_LOG2 = 6,
	parameter int OUT_DEPTH_LOG2  = 4
) (
	input  logic        ti_clk,
	input  logic        rst,
	input  logic        in_empty,
	input  word_t       in_head,
	output logic        in_pop,
	output logic        out_push,
	output word_t       out_data,
	input  credit_ret_t credit_ret,
	output level_t      ring_level
);

	localparam int RING_DEPTH = 1 << RING_DEPTH_LOG2;
	localparam int CREDITS    = 1 << OUT_DEPTH_LOG2;

	// bulk memory, stands in for the external SDRAM
	word_t ring_mem [RING_DEPTH];

	// pointers carry one extra bit to tell full from empty
	logic [RING_DEPTH_LOG2:0] wr_ptr;
	logic [RING_DEPTH_LOG2:0] rd_ptr;
	logic [RING_DEPTH_LOG2:0] stored;
	logic                     ring_empty;
	logic                     ring_full;

	// free slots in the output FIFO, seen from this side
	logic [OUT_DEPTH_LOG2:0] credits;
	logic                    rd_issue;

	// registered read port
	word_t rd_data;
	logic  rd_valid;

	assign stored     = wr_ptr - rd_ptr;
	assign ring_empty = (stored == '0);
	assign ring_full  = (stored == (RING_DEPTH_LOG2+1)'(RING_DEPTH));

	//////////////////////////////
	// fill side
	//////////////////////////////

	// input FIFO head is valid in the same cycle
	// a full ring stalls the fill, it never laps
	assign in_pop = ~in_empty & ~ring_full;

	always_ff @(posedge ti_clk) begin
		if (in_pop) begin
			ring_mem[wr_ptr[RING_DEPTH_LOG2-1:0]] <= in_head;
		end
	end

	//////////////////////////////
	// drain side
	//////////////////////////////

	// one credit per read, reads may go back to back
	assign rd_issue = ~ring_empty & (credits != '0);

	always_ff @(posedge ti_clk) begin
		if (rst) begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			credits  <= (OUT_DEPTH_LOG2+1)'(CREDITS);
			rd_valid <= 1'b0;
		end else begin
			if (in_pop) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (rd_issue) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			// spent on a read, returned on each output FIFO pop
			credits <= credits - (OUT_DEPTH_LOG2+1)'(rd_issue)
				+ (OUT_DEPTH_LOG2+1)'(credit_ret.pop);
			rd_valid <= rd_issue;
		end
	end

	always_ff @(posedge ti_clk) begin
		if (rd_issue) begin
			rd_data <= ring_mem[rd_ptr[RING_DEPTH_LOG2-1:0]];
		end
	end

	// word read last cycle goes straight into the output FIFO
	assign out_push = rd_valid;
	assign out_data = rd_data;

	// a word in the read register still belongs to the ring
	// so the capacity sum has no gap while it moves
	assign ring_level = level_t'(stored) + level_t'(rd_valid);

endmodule

/* verilog/occupancy_monitor.sv */
`timescale 1ns/1ps

module occupancy_monitor
	import buffer_ctrl_pkg::*;
#(
	parameter int IN_DEPTH_LOG2   = 4,
	parameter int RING_DEPTH_LOG2 = 6,
	parameter int BLOCK_WORDS     = 8
) (
	input  logic          ti_clk,
	input  logic          rst,
	input  level_t        in_level,
	input  logic          half_held,
	input  level_t        ring_level,
	input  credit_ret_t   credit_ret,
	output sample_count_t num_words,
	output logic          out_rdy
);

	// word counts of each stage widened to the report width
	sample_count_t in_words;
	sample_count_t ring_words;
	sample_count_t out_words;

	// input FIFO holds at most 2^IN_DEPTH_LOG2 words
	assign in_words   = sample_count_t'(in_level[IN_DEPTH_LOG2:0]);
	// ring holds 2^RING_DEPTH_LOG2 plus the one word in the read register
	assign ring_words = sample_count_t'(ring_level[RING_DEPTH_LOG2:0]);
	assign out_words  = sample_count_t'(credit_ret.level);

	//////////////////////////////
	// capacity and block flag
	//////////////////////////////

	always_ff @(posedge ti_clk) begin
		if (rst) begin
			num_words <= '0;
			out_rdy   <= 1'b0;
		end else begin
			// two samples per word plus the odd one in the packer
			num_words <= ((in_words + ring_words + out_words) << 1)
				+ sample_count_t'(half_held);
			// host only starts a block transfer on a full block
			out_rdy <= (credit_ret.level >= level_t'(BLOCK_WORDS));
		end
	end

endmodule

/* verilog/stream_buffer_top.sv */
`timescale 1ns/1ps

module stream_buffer_top
	import sample_fmt_pkg::*;
	import buffer_ctrl_pkg::*;
#(
	parameter int IN_DEPTH_LOG2   = 4,
	parameter int RING_DEPTH_LOG2 = 6,
	parameter int OUT_DEPTH_LOG2  = 4,
	parameter int BLOCK_WORDS     = 8
) (
	input  logic          ti_clk,
	input  logic          rst,
	input  logic          write_en,
	input  sample_t       sample_in,
	input  logic          read_en,
	output word_t         data_out,
	output logic          out_rdy,
	output sample_count_t num_words
);

	// packer to input FIFO
	logic         pack_push;
	sample_pair_u pack_word;
	logic         half_held;

	// input FIFO to engine
	word_t  in_head;
	logic   in_empty;
	logic   in_pop;
	level_t in_level;

	// engine to output FIFO, and credits back
	logic        out_push;
	word_t       out_data;
	credit_ret_t credit_ret;
	level_t      ring_level;

	sample_packer packer0 (
		.ti_clk    (ti_clk),
		.rst       (rst),
		.write_en  (write_en),
		.sample_in (sample_in),
		.push      (pack_push),
		.push_word (pack_word),
		.half_held (half_held)
	);

	mini_fifo #(.DEPTH_LOG2(IN_DEPTH_LOG2)) in_fifo (
		.ti_clk     (ti_clk),
		.rst        (rst),
		.push       (pack_push),
		.push_data  (pack_word.raw),
		.pop        (in_pop),
		.head       (in_head),
		.empty      (in_empty),
		.full       (),
		.level      (in_level),
		.credit_ret ()
	);

	ring_transfer_engine #(
		.RING_DEPTH_LOG2 (RING_DEPTH_LOG2),
		.OUT_DEPTH_LOG2  (OUT_DEPTH_LOG2)
	) engine0 (
		.ti_clk     (ti_clk),
		.rst        (rst),
		.in_empty   (in_empty),
		.in_head    (in_head),
		.in_pop     (in_pop),
		.out_push   (out_push),
		.out_data   (out_data),
		.credit_ret (credit_ret),
		.ring_level (ring_level)
	);

	// host side, read_en pops the head shown on data_out
	mini_fifo #(.DEPTH_LOG2(OUT_DEPTH_LOG2)) out_fifo (
		.ti_clk     (ti_clk),
		.rst        (rst),
		.push       (out_push),
		.push_data  (out_data),
		.pop        (read_en),
		.head       (data_out),
		.empty      (),
		.full       (),
		.level      (),
		.credit_ret (credit_ret)
	);

	occupancy_monitor #(
		.IN_DEPTH_LOG2   (IN_DEPTH_LOG2),
		.RING_DEPTH_LOG2 (RING_DEPTH_LOG2),
		.BLOCK_WORDS     (BLOCK_WORDS)
	) monitor0 (
		.ti_clk     (ti_clk),
		.rst        (rst),
		.in_level   (in_level),
		.half_held  (half_held),
		.ring_level (ring_level),
		.credit_ret (credit_ret),
		.num_words  (num_words),
		.out_rdy    (out_rdy)
	);

endmodule

/* dv/stream_buffer_tb.sv */
`timescale 1ns/1ps

module stream_buffer_tb
	import sample_fmt_pkg::*;
	import buffer_ctrl_pkg::*;
();

	localparam int IN_DEPTH_LOG2   = 4;
	localparam int RING_DEPTH_LOG2 = 6;
	localparam int OUT_DEPTH_LOG2  = 4;
	localparam int BLOCK_WORDS     = 8;
	localparam int OUT_DEPTH       = 1 << OUT_DEPTH_LOG2;
	localparam int CLK_PERIOD      = 10;
	// quiet time for the ring to drain into the output FIFO
	localparam int SETTLE_CYCLES   = (1 << RING_DEPTH_LOG2) + 20;
	localparam int STREAM_SAMPLES  = 24;
	localparam int BURST_SAMPLES   = 60;
	// stream, odd sample and its partner, then the burst
	localparam int TOTAL_SAMPLES   = STREAM_SAMPLES + 2 + BURST_SAMPLES;
	localparam int WATCHDOG_CYCLES = 40 * TOTAL_SAMPLES + 2000;

	logic          ti_clk;
	logic          rst;
	logic          write_en;
	sample_t       sample_in;
	logic          read_en;
	word_t         data_out;
	logic          out_rdy;
	sample_count_t num_words;

	// reference model
	word_t   ref_q[$];
	sample_t half_sample;
	logic    have_half;
	word_t   last_expected;
	int      samples_written;
	int      words_read;
	int      errors;
	int      seed;
	string   test_name;
	logic    stream_done;

	// expected values driven on the clock edge like the inputs
	logic          pop_check;
	word_t         exp_word;
	logic          idle_check;
	sample_count_t exp_count;
	logic          exp_rdy;
	logic          hold_check;
	word_t         exp_last;

	stream_buffer_top #(
		.IN_DEPTH_LOG2   (IN_DEPTH_LOG2),
		.RING_DEPTH_LOG2 (RING_DEPTH_LOG2),
		.OUT_DEPTH_LOG2  (OUT_DEPTH_LOG2),
		.BLOCK_WORDS     (BLOCK_WORDS)
	) dut0 (
		.ti_clk    (ti_clk),
		.rst       (rst),
		.write_en  (write_en),
		.sample_in (sample_in),
		.read_en   (read_en),
		.data_out  (data_out),
		.out_rdy   (out_rdy),
		.num_words (num_words)
	);

	initial begin
		ti_clk = 1'b0;
		forever #(CLK_PERIOD / 2) ti_clk = ~ti_clk;
	end

	task automatic log_mismatch(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		errors++;
		$display("** Error [%s] %s: expected %h, actual %h", test_name, what, expected, actual);
	endtask

	//////////////////////////////
	// checks
	//////////////////////////////

	// popped word against the next reference pair
	assert property (@(posedge ti_clk) disable iff (rst) pop_check |-> data_out == exp_word)
		else log_mismatch("data_out", $sampled(exp_word), $sampled(data_out));

	// fill in samples where an odd leftover counts as one
	assert property (@(posedge ti_clk) disable iff (rst) idle_check |-> num_words == exp_count)
		else log_mismatch("num_words", $sampled(exp_count), $sampled(num_words));

	assert property (@(posedge ti_clk) disable iff (rst) idle_check |-> out_rdy == exp_rdy)
		else log_mismatch("out_rdy", 32'($sampled(exp_rdy)), 32'($sampled(out_rdy)));

	// head keeps the last popped word and reads zero before the first pop
	assert property (@(posedge ti_clk) disable iff (rst) hold_check |-> data_out == exp_last)
		else log_mismatch("data_out held", $sampled(exp_last), $sampled(data_out));

	//////////////////////////////
	// stimulus
	//////////////////////////////

	task automatic send_samples(input int n, input int max_gap);
		sample_t s;
		int      gap;
		for (int i = 0; i < n; i++) begin
			s = sample_t'($random(seed));
			@(posedge ti_clk);
			write_en  <= 1'b1;
			sample_in <= s;
			// pairs form in arrival order with the early sample in the low half
			if (have_half) begin
				ref_q.push_back({s, half_sample});
			end else begin
				half_sample = s;
			end
			have_half = ~have_half;
			samples_written++;
			gap = $unsigned($random(seed)) % (max_gap + 1);
			repeat (gap) begin
				@(posedge ti_clk);
				write_en <= 1'b0;
			end
		end
		@(posedge ti_clk);
		write_en <= 1'b0;
	endtask

	// one pop checked against the reference on the next edge
	task automatic issue_read();
		read_en   <= 1'b1;
		pop_check <= 1'b1;
		if (ref_q.size() == 0) begin
			errors++;
			$display("a read was issued with no expected word left");
		end else begin
			last_expected = ref_q.pop_front();
			exp_word <= last_expected;
		end
		words_read++;
	endtask

	task automatic read_words(input int n);
		repeat (n) begin
			@(posedge ti_clk);
			issue_read();
		end
		@(posedge ti_clk);
		read_en   <= 1'b0;
		pop_check <= 1'b0;
	endtask

	// with the inputs quiet the fill and block flag must match the reference
	task automatic check_idle();
		int pairs;
		repeat (SETTLE_CYCLES) @(posedge ti_clk);
		pairs = samples_written / 2 - words_read;
		exp_count <= sample_count_t'(samples_written - 2 * words_read);
		// output FIFO takes up to its depth and the rest waits in the ring
		exp_rdy    <= ((pairs > OUT_DEPTH ? OUT_DEPTH : pairs) >= BLOCK_WORDS);
		idle_check <= 1'b1;
		repeat (2) @(posedge ti_clk);
		idle_check <= 1'b0;
	endtask

	task automatic drain_all();
		int pending;
		check_idle();
		pending = samples_written / 2 - words_read;
		while (pending > 0) begin
			// after settling the whole known level sits in the output FIFO
			read_words(pending > OUT_DEPTH ? OUT_DEPTH : pending);
			check_idle();
			pending = samples_written / 2 - words_read;
		end
	endtask

	initial begin
		seed            = 32'haf31_4112;
		have_half       = 1'b0;
		half_sample     = '0;
		last_expected   = '0;
		samples_written = 0;
		words_read      = 0;
		errors          = 0;
		test_name       = "reset";
		stream_done <= 1'b0;
		rst         <= 1'b1;
		write_en    <= 1'b0;
		sample_in   <= '0;
		read_en     <= 1'b0;
		pop_check   <= 1'b0;
		exp_word    <= '0;
		idle_check  <= 1'b0;
		exp_count   <= '0;
		exp_rdy     <= 1'b0;
		hold_check  <= 1'b0;
		exp_last    <= '0;
		repeat (3) @(posedge ti_clk);
		rst        <= 1'b0;
		idle_check <= 1'b1;
		hold_check <= 1'b1;
		repeat (4) @(posedge ti_clk);
		idle_check <= 1'b0;
		hold_check <= 1'b0;

		// random gaps on the write side while reads follow out_rdy
		test_name = "stream";
		fork
			begin
				send_samples(STREAM_SAMPLES, 3);
				stream_done <= 1'b1;
			end
			begin
				while (!stream_done) begin
					@(posedge ti_clk);
					// out_rdy lags, but a full block leaves margin
					if (out_rdy) begin
						issue_read();
					end else begin
						read_en   <= 1'b0;
						pop_check <= 1'b0;
					end
				end
				@(posedge ti_clk);
				read_en   <= 1'b0;
				pop_check <= 1'b0;
			end
		join

		test_name = "occupancy";
		check_idle();
		test_name = "odd sample";
		send_samples(1, 0);
		check_idle();
		send_samples(1, 0);

		// no reads during the burst so the output FIFO spills into the ring
		test_name = "backpressure";
		send_samples(BURST_SAMPLES, 0);
		drain_all();

		test_name = "underflow";
		exp_last   <= last_expected;
		exp_count  <= '0;
		exp_rdy    <= 1'b0;
		hold_check <= 1'b1;
		idle_check <= 1'b1;
		read_en    <= 1'b1;
		repeat (6) @(posedge ti_clk);
		read_en <= 1'b0;
		repeat (2) @(posedge ti_clk);
		hold_check <= 1'b0;
		idle_check <= 1'b0;

		$display("summary: %0d errors, %0d samples written, %0d words read",
			errors, samples_written, words_read);
		if (errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

	// watchdog scaled to the number of samples in the run
	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("watchdog expired after %0d cycles before the run finished", WATCHDOG_CYCLES);
		$display("summary: %0d errors, %0d samples written, %0d words read",
			errors, samples_written, words_read);
		$display("Errors found");
		$finish;
	end

endmodule

/* stream_buffer_top.f */
verilog/sample_fmt_pkg.sv
verilog/buffer_ctrl_pkg.sv
verilog/sample_packer.sv
verilog/mini_fifo.sv
verilog/ring_transfer_engine.sv
verilog/occupancy_monitor.sv
verilog/stream_buffer_top.sv
dv/stream_buffer_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the stream buffer testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

TOP=stream_buffer_tb
BUILD_DIR=obj_dir

if ! command -v verilator > /dev/null 2>&1; then
	echo "verilator not found on PATH"
	exit 1
fi

if ! verilator --binary --timing --assert --top-module "$TOP" \
	--Mdir "$BUILD_DIR" -f stream_buffer_top.f; then
	echo "verilator build failed"
	exit 1
fi

output=$("./$BUILD_DIR/V$TOP")
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -qx "No errors"; then
	exit 0
fi
exit 1
